/* crc_link.f */
+incdir+include
source/crc_link_pkg.sv
source/byte_ingress.sv
source/crc16_engine.sv
source/frame_report.sv
source/crc_link.sv
test/tb_crc_link.sv

/* include/crc_link_consts.svh */
// crc link constants: generator polynomial, seed value and frame length width
`ifndef CRC_LINK_CONSTS_SVH
`define CRC_LINK_CONSTS_SVH

// crc-16 generator, non-reflected
`define CRC_POLY 16'h8005

// seed at reset and at every frame start
`define CRC_INIT 16'h0000

// frame length counter width, wraps past 255
`define LEN_W 8

`endif

/* run_sim.sh */
#!/bin/sh
# build and run the crc link testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module tb_crc_link \
    -f crc_link.f \
    -o tb_crc_link
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

if [ ! -x ./obj_dir/tb_crc_link ]; then
    echo "simulation binary obj_dir/tb_crc_link not found"
    exit 1
fi

./obj_dir/tb_crc_link
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation ended with status $sim_status"
    exit $sim_status
fi

echo "simulation ended with status 0"
exit 0

/* source/byte_ingress.sv */
// byte ingress: tracks frame boundaries and applies bit-inversion error injection
`timescale 1ns/1ps

module byte_ingress (
    input  logic                clk,
    input  logic                rst_n,
    input  crc_link_pkg::byte_t data_in,
    input  logic                inject_err,
    input  logic                last,
    input  logic                accept,
    output crc_link_pkg::byte_t byte_data,
    output logic                byte_first,
    output logic                byte_last,
    output logic                byte_corrupt
);

    // set once a byte of the current frame has been taken
    logic in_frame;

    // injection flips every bit before the checksum sees it
    always_comb begin
        if (inject_err) begin
            byte_data = ~data_in;
        end else begin
            byte_data = data_in;
        end
    end

    // nothing accepted yet in this frame
    assign byte_first = ~in_frame;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_frame <= 1'b0;
        end else if (accept) begin
            // last byte closes the frame, anything else keeps it open
            if (last) begin
                in_frame <= 1'b0;
            end else begin
                in_frame <= 1'b1;
            end
        end
    end

    // byte attributes held for the output side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_last    <= 1'b0;
            byte_corrupt <= 1'b0;
        end else if (accept) begin
            byte_last    <= last;
            byte_corrupt <= inject_err;
        end
    end

endmodule

/* source/crc16_engine.sv */
// crc-16 engine: valid/ready byte FSM updating a running crc with per-frame restart
`timescale 1ns/1ps
`include "crc_link_consts.svh"

module crc16_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid,
    input  crc_link_pkg::byte_t byte_data,
    input  logic                byte_first,
    output logic                ready,
    output logic                accept,
    output crc_link_pkg::crc_t  crc,
    output logic                data_processed,
    output logic                byte_done
);

    crc_link_pkg::engine_state_t state;
    crc_link_pkg::engine_state_t next_state;

    // byte and seed select captured at accept
    crc_link_pkg::byte_t data_q;
    logic                first_q;

    // result of the step, published one cycle later
    crc_link_pkg::crc_t  temp_crc;
    logic                calc_done;

    // one byte, lsb first, msb-first shift register
    function automatic crc_link_pkg::crc_t crc16_step(
        input crc_link_pkg::byte_t data,
        input crc_link_pkg::crc_t  crc_in
    );
        crc_link_pkg::crc_t c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if ((data[i] ^ c[15]) == 1'b1) begin
                c = {c[14:0], 1'b0} ^ `CRC_POLY;
            end else begin
                c = {c[14:0], 1'b0};
            end
        end
        return c;
    endfunction

    assign accept = (state == crc_link_pkg::IDLE) && valid && ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= crc_link_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            crc_link_pkg::IDLE: begin
                if (accept) begin
                    next_state = crc_link_pkg::PROCESS;
                end
            end
            crc_link_pkg::PROCESS: begin
                // two cycles here, compute then publish
                if (calc_done) begin
                    next_state = crc_link_pkg::COMPLETE;
                end
            end
            crc_link_pkg::COMPLETE: begin
                if (!valid) begin
                    next_state = crc_link_pkg::IDLE;
                end
            end
            default: next_state = crc_link_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready          <= 1'b1;
            crc            <= `CRC_INIT;
            data_processed <= 1'b0;
            byte_done      <= 1'b0;
            calc_done      <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            case (state)
                crc_link_pkg::IDLE: begin
                    data_processed <= 1'b0;
                    if (accept) begin
                        ready <= 1'b0;
                    end
                end
                crc_link_pkg::PROCESS: begin
                    if (!calc_done) begin
                        calc_done <= 1'b1;
                    end else begin
                        calc_done      <= 1'b0;
                        crc            <= temp_crc;
                        data_processed <= 1'b1;
                        byte_done      <= 1'b1;
                    end
                end
                crc_link_pkg::COMPLETE: begin
                    // hold off until the producer lets go of valid
                    if (!valid) begin
                        ready          <= 1'b1;
                        data_processed <= 1'b0;
                    end
                end
                default: begin
                    ready          <= 1'b1;
                    data_processed <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q  <= byte_data;
            first_q <= byte_first;
        end
        // first byte of a frame restarts from the init value
        if ((state == crc_link_pkg::PROCESS) && !calc_done) begin
            temp_crc <= crc16_step(data_q, first_q ? `CRC_INIT : crc);
        end
    end

endmodule

/* source/crc_link.sv */
// crc link top: ingress, crc-16 engine and frame report in a byte-serial chain
`timescale 1ns/1ps

module crc_link (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid,
    input  logic                inject_err,
    input  logic                last,
    input  crc_link_pkg::byte_t data_in,
    output logic                ready,
    output crc_link_pkg::crc_t  crc,
    output logic                data_processed,
    output logic                frame_done,
    output crc_link_pkg::crc_t  frame_crc,
    output crc_link_pkg::len_t  frame_len,
    output logic                frame_corrupt
);

    // ingress to engine
    crc_link_pkg::byte_t byte_data;
    logic                byte_first;
    logic                accept;

    // ingress and engine to report
    logic                byte_last;
    logic                byte_corrupt;
    logic                byte_done;

    byte_ingress i_byte_ingress (
        .clk          (clk),
        .rst_n        (rst_n),
        .data_in      (data_in),
        .inject_err   (inject_err),
        .last         (last),
        .accept       (accept),
        .byte_data    (byte_data),
        .byte_first   (byte_first),
        .byte_last    (byte_last),
        .byte_corrupt (byte_corrupt)
    );

    crc16_engine i_crc16_engine (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid          (valid),
        .byte_data      (byte_data),
        .byte_first     (byte_first),
        .ready          (ready),
        .accept         (accept),
        .crc            (crc),
        .data_processed (data_processed),
        .byte_done      (byte_done)
    );

    frame_report i_frame_report (
        .clk           (clk),
        .rst_n         (rst_n),
        .byte_done     (byte_done),
        .byte_last     (byte_last),
        .byte_corrupt  (byte_corrupt),
        .crc           (crc),
        .frame_done    (frame_done),
        .frame_crc     (frame_crc),
        .frame_len     (frame_len),
        .frame_corrupt (frame_corrupt)
    );

endmodule

/* source/crc_link_pkg.sv */
// crc link package: shared byte, crc, length and engine state types
`include "crc_link_consts.svh"

package crc_link_pkg;

    // one payload byte
    typedef logic [7:0] byte_t;

    // running or final crc value
    typedef logic [15:0] crc_t;

    // frame length in bytes
    typedef logic [`LEN_W-1:0] len_t;

    // engine FSM
    //   IDLE     waiting for a byte
    //   PROCESS  computing and publishing the crc
    //   COMPLETE waiting for the producer to drop valid
    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        PROCESS  = 2'b01,
        COMPLETE = 2'b10
    } engine_state_t;

endpackage

/* source/frame_report.sv */
// frame report: counts bytes, tracks corruption and announces each finished frame
`timescale 1ns/1ps
`include "crc_link_consts.svh"

module frame_report (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               byte_done,
    input  logic               byte_last,
    input  logic               byte_corrupt,
    input  crc_link_pkg::crc_t crc,
    output logic               frame_done,
    output crc_link_pkg::crc_t frame_crc,
    output crc_link_pkg::len_t frame_len,
    output logic               frame_corrupt
);

    // bytes of the open frame so far
    crc_link_pkg::len_t byte_cnt;
    // sticky, any injected byte in the open frame
    logic               corrupt_acc;

    crc_link_pkg::len_t next_len;
    logic               next_corrupt;

    // totals including the byte just finished
    assign next_len     = byte_cnt + 1'b1;
    assign next_corrupt = corrupt_acc | byte_corrupt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt    <= '0;
            corrupt_acc <= 1'b0;
        end else if (byte_done) begin
            if (byte_last) begin
                byte_cnt    <= '0;
                corrupt_acc <= 1'b0;
            end else begin
                byte_cnt    <= next_len;
                corrupt_acc <= next_corrupt;
            end
        end
    end

    // one-cycle strobe on the last byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= byte_done & byte_last;
        end
    end

    // results held until the next frame ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_crc     <= `CRC_INIT;
            frame_len     <= '0;
            frame_corrupt <= 1'b0;
        end else if (byte_done && byte_last) begin
            frame_crc     <= crc;
            frame_len     <= next_len;
            frame_corrupt <= next_corrupt;
        end
    end

endmodule

/* test/tb_crc_link.sv */
// crc link testbench driving directed frames, injection and back-pressure against a crc model
`timescale 1ns/1ps
`include "crc_link_consts.svh"

module tb_crc_link;

    logic                clk;
    logic                rst_n;
    logic                valid;
    logic                inject_err;
    logic                last;
    crc_link_pkg::byte_t data_in;
    logic                ready;
    crc_link_pkg::crc_t  crc;
    logic                data_processed;
    logic                frame_done;
    crc_link_pkg::crc_t  frame_crc;
    crc_link_pkg::len_t  frame_len;
    logic                frame_corrupt;

    // model of the open frame
    crc_link_pkg::crc_t  model_crc;
    logic                model_first;
    int                  model_len;
    logic                model_corrupt;

    int                  cycles;
    int                  bytes_sent;

    crc_link i_crc_link (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid          (valid),
        .inject_err     (inject_err),
        .last           (last),
        .data_in        (data_in),
        .ready          (ready),
        .crc            (crc),
        .data_processed (data_processed),
        .frame_done     (frame_done),
        .frame_crc      (frame_crc),
        .frame_len      (frame_len),
        .frame_corrupt  (frame_corrupt)
    );

    always #10 clk = ~clk;

    // budget grows with every byte sent
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > 20 * bytes_sent + 200) begin
            $display("** FAIL **");
            $fatal(1, "timeout: no progress after %0d cycles and %0d bytes",
                   cycles, bytes_sent);
        end
    end

    // data bits lsb first into a msb-first register
    function automatic crc_link_pkg::crc_t crc_ref(
        input crc_link_pkg::byte_t d,
        input crc_link_pkg::crc_t  seed
    );
        crc_link_pkg::crc_t r;
        logic               fb;
        r = seed;
        for (int b = 0; b < 8; b++) begin
            fb = d[b] ^ r[15];
            r  = (r << 1) ^ ({16{fb}} & `CRC_POLY);
        end
        return r;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("ERROR at %0t: %s got 0x%0h expected 0x%0h", $time, what, got, want);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // one byte through the handshake
    // s counts edges after the accept edge N
    task automatic send_byte(
        input crc_link_pkg::byte_t d,
        input logic                is_last,
        input logic                inj,
        input int                  hold
    );
        crc_link_pkg::byte_t eff;
        crc_link_pkg::crc_t  want;
        int                  s;
        int                  fd_count;
        int                  fd_at;
        eff           = inj ? ~d : d;
        want          = crc_ref(eff, model_first ? `CRC_INIT : model_crc);
        model_crc     = want;
        model_len     = model_len + 1;
        model_corrupt = model_corrupt | inj;
        model_first   = is_last;
        bytes_sent    = bytes_sent + 1;
        fd_count      = 0;
        fd_at         = -1;

        valid      <= 1'b1;
        data_in    <= d;
        last       <= is_last;
        inject_err <= inj;

        do begin
            @(posedge clk);
        end while (!ready);

        // edge N+2 publishes crc so sample 3 sees it
        s = 0;
        do begin
            @(posedge clk);
            s = s + 1;
            if (frame_done) begin
                fd_count = fd_count + 1;
                fd_at    = s;
            end
        end while (!data_processed);
        check(32'(s), 32'd3, "accept to crc latency");
        check(32'(crc), 32'(want), "crc after byte");

        // engine must stall while valid stays up
        for (int k = 0; k < hold; k++) begin
            @(posedge clk);
            s = s + 1;
            if (frame_done) begin
                fd_count = fd_count + 1;
                fd_at    = s;
            end
            check(32'(ready), 32'd0, "ready during back-pressure");
            check(32'(data_processed), 32'd1, "data_processed during back-pressure");
            check(32'(crc), 32'(want), "crc hold during back-pressure");
        end

        valid <= 1'b0;
        repeat (2) begin
            @(posedge clk);
            s = s + 1;
            if (frame_done) begin
                fd_count = fd_count + 1;
                fd_at    = s;
            end
        end
        check(32'(ready), 32'd1, "ready after valid drop");
        check(32'(data_processed), 32'd0, "data_processed after valid drop");
        check(32'(crc), 32'(want), "crc after valid drop");

        if (is_last) begin
            // set by edge N+3 and seen at sample 4
            check(32'(fd_count), 32'd1, "frame_done pulse count");
            check(32'(fd_at), 32'd4, "accept to frame_done latency");
            check(32'(frame_crc), 32'(want), "frame_crc");
            check(32'(frame_len), 32'(model_len), "frame_len");
            check(32'(frame_corrupt), 32'(model_corrupt), "frame_corrupt");
            model_len     = 0;
            model_corrupt = 1'b0;
        end else begin
            check(32'(fd_count), 32'd0, "frame_done inside a frame");
        end
    endtask

    task automatic test_reset_state();
        check(32'(ready), 32'd1, "ready after reset");
        check(32'(data_processed), 32'd0, "data_processed after reset");
        check(32'(frame_done), 32'd0, "frame_done after reset");
        check(32'(crc), 32'(`CRC_INIT), "crc after reset");
        check(32'(frame_crc), 32'(`CRC_INIT), "frame_crc after reset");
        check(32'(frame_len), 32'd0, "frame_len after reset");
        check(32'(frame_corrupt), 32'd0, "frame_corrupt after reset");
    endtask

    task automatic test_single_byte();
        crc_link_pkg::byte_t d;
        crc_link_pkg::crc_t  want;
        d    = 8'($urandom);
        want = crc_ref(d, `CRC_INIT);
        send_byte(d, 1'b1, 1'b0, 0);
        check(32'(crc), 32'(want), "single byte crc");
        check(32'(frame_crc), 32'(want), "single byte frame_crc");
        check(32'(frame_len), 32'd1, "single byte frame_len");
    endtask

    task automatic test_random_frames();
        crc_link_pkg::byte_t d;
        crc_link_pkg::crc_t  want;
        int                  len;
        for (int f = 0; f < 4; f++) begin
            len  = $urandom_range(12, 2);
            want = `CRC_INIT;
            for (int i = 0; i < len; i++) begin
                d    = 8'($urandom);
                want = crc_ref(d, want);
                send_byte(d, i == len - 1, 1'b0, 0);
                check(32'(crc), 32'(want), "running crc");
            end
            check(32'(frame_len), 32'(len), "random frame length");
            check(32'(frame_crc), 32'(want), "random frame crc");
        end
    endtask

    task automatic test_injection();
        crc_link_pkg::byte_t d;
        crc_link_pkg::crc_t  want;
        int                  pick;
        logic                inj;
        pick = $urandom_range(4, 0);
        want = `CRC_INIT;
        for (int i = 0; i < 5; i++) begin
            d    = 8'($urandom);
            inj  = (i == pick);
            want = crc_ref(inj ? ~d : d, want);
            send_byte(d, i == 4, inj, 0);
        end
        check(32'(frame_crc), 32'(want), "injected frame crc");
        check(32'(frame_corrupt), 32'd1, "injected frame corrupt flag");

        // clean frame right after must not inherit the flag
        want = `CRC_INIT;
        for (int i = 0; i < 3; i++) begin
            d    = 8'($urandom);
            want = crc_ref(d, want);
            send_byte(d, i == 2, 1'b0, 0);
        end
        check(32'(frame_crc), 32'(want), "clean frame crc");
        check(32'(frame_corrupt), 32'd0, "clean frame corrupt flag");
    endtask

    task automatic test_back_pressure();
        crc_link_pkg::byte_t d;
        crc_link_pkg::crc_t  want;
        want = `CRC_INIT;
        for (int i = 0; i < 3; i++) begin
            d    = 8'($urandom);
            want = crc_ref(d, want);
            send_byte(d, i == 2, 1'b0, (i == 1) ? 10 : 0);
        end
        check(32'(frame_len), 32'd3, "frame_len after back-pressure");
        check(32'(frame_crc), 32'(want), "frame_crc after back-pressure");
    endtask

    initial begin
        clk           = 1'b0;
        cycles        = 0;
        bytes_sent    = 0;
        model_crc     = `CRC_INIT;
        model_first   = 1'b1;
        model_len     = 0;
        model_corrupt = 1'b0;
        rst_n      <= 1'b0;
        valid      <= 1'b0;
        inject_err <= 1'b0;
        last       <= 1'b0;
        data_in    <= 8'h00;
        void'($urandom(37));

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        test_reset_state();
        test_single_byte();
        test_random_frames();
        test_injection();
        test_back_pressure();

        $display("** PASS **");
        $finish;
    end

endmodule
